// ==== Bender.yml ====
package:
  name: mlpInfer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/mlpTypes.sv
      - source/mlpWeights.sv
      - source/neuronNode.sv
      - source/denseLayer.sv
      - source/inputPort.sv
      - source/argmaxUnit.sv
      - source/resultPort.sv
      - source/mlpTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tbMlp.sv

// ==== include/mlp_consts.svh ====
`ifndef MLP_CONSTS_SVH
`define MLP_CONSTS_SVH

// Network shape.
`define MLP_INPUTS 10
`define MLP_HIDDEN 10
`define MLP_CLASSES 4

// Accumulator bits dropped when the sum is scaled back to an activation.
`define MLP_FRAC_SHIFT 6

// Register stages through one neuron.
`define MLP_NODE_LATENCY 3

// Result queue entries, and the number of vectors allowed in flight.
`define MLP_RESULT_DEPTH 4

`endif

// ==== mlpInfer.f ====
+incdir+include
source/mlpTypes.sv
source/mlpWeights.sv
source/neuronNode.sv
source/denseLayer.sv
source/inputPort.sv
source/argmaxUnit.sv
source/resultPort.sv
source/mlpTop.sv
test/tbMlp.sv

// ==== source/argmaxUnit.sv ====
`include "mlp_consts.svh"

module argmaxUnit
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlpTypes::scoreVecT scores,
	output logic resValid,
	output mlpTypes::resultT result
);

	mlpTypes::classIdxT bestIdx;
	mlpTypes::activationT bestScore;

	// Strict compare keeps the lowest index on a tie.
	always_comb
	begin
		bestIdx = '0;
		bestScore = scores.score[0];
		for (int i = 1; i < `MLP_CLASSES; i++)
		begin
			if (scores.score[i] > bestScore)
			begin
				bestIdx = mlpTypes::classIdxT'(i);
				bestScore = scores.score[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		resValid <= reset ? 1'b0 : inValid;
		result.classIdx <= bestIdx;
		result.scores <= scores;
	end

endmodule

// ==== source/denseLayer.sv ====
`include "mlp_consts.svh"

module denseLayer
#(
	parameter int INPUTS = `MLP_INPUTS,
	parameter int NODES = `MLP_HIDDEN,
	parameter mlpTypes::weightT [0:NODES-1][0:INPUTS-1] weights = '0,
	parameter mlpTypes::weightT [0:NODES-1] bias = '0
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlpTypes::activationT [INPUTS-1:0] inVec,
	output logic outValid,
	output mlpTypes::activationT [NODES-1:0] outVec
);

	logic [`MLP_NODE_LATENCY-1:0] validPipe;

	for (genvar n = 0; n < NODES; n++)
	begin : nodes
		neuronNode
		#(
			.weights(weights[n]),
			.bias(bias[n])
		)
		node_i
		(
			.clk(clk),
			.reset(reset),
			.activations(inVec),
			.activation(outVec[n])
		);
	end

	// Follows each vector through the neuron stages.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[`MLP_NODE_LATENCY-2:0], inValid};
		end
	end

	assign outValid = validPipe[`MLP_NODE_LATENCY-1];

endmodule

// ==== source/inputPort.sv ====
`include "mlp_consts.svh"

module inputPort
(
	input logic clk,
	input logic reset,
	input logic inReq,
	input mlpTypes::featureVecT inData,
	output logic inAck,
	input logic retire,
	output logic start,
	output mlpTypes::featureVecT feature
);

	typedef enum logic [1:0] {idleSt, ackSt, releaseSt} portStateT;

	portStateT state;
	logic [$clog2(`MLP_RESULT_DEPTH+1)-1:0] credits;
	logic accept;

	assign accept = (state == idleSt) && inReq && (credits != '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idleSt;
			inAck <= 1'b0;
			start <= 1'b0;
			credits <= `MLP_RESULT_DEPTH;
		end
		else
		begin
			start <= accept;
			case (state)
				idleSt:
				begin
					if (accept)
					begin
						inAck <= 1'b1;
						state <= ackSt;
					end
				end
				ackSt:
				begin
					if (!inReq)
					begin
						state <= releaseSt;    // Sender has let go.
					end
				end
				default:
				begin
					inAck <= 1'b0;
					state <= idleSt;
				end
			endcase
			if (accept && !retire)
			begin
				credits <= credits - 1'b1;
			end
			else if (retire && !accept)
			begin
				credits <= credits + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			feature <= inData;
		end
	end

endmodule

// ==== source/mlpTop.sv ====
`include "mlp_consts.svh"

module mlpTop
(
	input logic clk,
	input logic reset,
	input logic inReq,
	input mlpTypes::featureVecT inData,
	output logic inAck,
	output logic outReq,
	output mlpTypes::resultT outData,
	input logic outAck
);

	logic start;
	logic retire;
	logic hiddenValid;
	logic scoreValid;
	logic resValid;
	mlpTypes::featureVecT feature;
	mlpTypes::hiddenVecT hiddenVec;
	mlpTypes::scoreVecT scoreVec;
	mlpTypes::resultT result;

	inputPort inputPort_i
	(
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.retire(retire),
		.start(start),
		.feature(feature)
	);

	denseLayer
	#(
		.INPUTS(`MLP_INPUTS),
		.NODES(`MLP_HIDDEN),
		.weights(mlpWeights::hiddenWeights),
		.bias(mlpWeights::hiddenBias)
	)
	hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(start),
		.inVec(feature.act),
		.outValid(hiddenValid),
		.outVec(hiddenVec.act)
	);

	denseLayer
	#(
		.INPUTS(`MLP_HIDDEN),
		.NODES(`MLP_CLASSES),
		.weights(mlpWeights::outputWeights),
		.bias(mlpWeights::outputBias)
	)
	outputLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.inVec(hiddenVec.act),
		.outValid(scoreValid),
		.outVec(scoreVec.score)
	);

	argmaxUnit argmaxUnit_i
	(
		.clk(clk),
		.reset(reset),
		.inValid(scoreValid),
		.scores(scoreVec),
		.resValid(resValid),
		.result(result)
	);

	resultPort resultPort_i
	(
		.clk(clk),
		.reset(reset),
		.resValid(resValid),
		.result(result),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck),
		.retire(retire)
	);

endmodule

// ==== source/mlpTypes.sv ====
`include "mlp_consts.svh"

package mlpTypes;

	typedef logic [7:0] activationT;           // Unsigned activation.
	typedef logic signed [7:0] weightT;        // Signed weight or bias.
	typedef logic signed [15:0] productT;
	typedef logic signed [15:0] accumT;        // Wraps on overflow.
	typedef logic [$clog2(`MLP_CLASSES)-1:0] classIdxT;

	typedef struct packed
	{
		activationT [`MLP_INPUTS-1:0] act;
	} featureVecT;

	typedef struct packed
	{
		activationT [`MLP_HIDDEN-1:0] act;
	} hiddenVecT;

	typedef struct packed
	{
		activationT [`MLP_CLASSES-1:0] score;
	} scoreVecT;

	typedef struct packed
	{
		classIdxT classIdx;
		scoreVecT scores;
	} resultT;

endpackage

// ==== source/mlpWeights.sv ====
`include "mlp_consts.svh"

package mlpWeights;

	// Row n holds the weights of hidden neuron n, column i multiplies input i.
	localparam mlpTypes::weightT [0:`MLP_HIDDEN-1][0:`MLP_INPUTS-1] hiddenWeights =
	'{
		'{  5,  -3,   8,   2,  -7,   4,   1,  -2,   6,   3 },
		'{ -4,   9,  -1,   3,   5,  -6,   2,   7,  -3,   1 },
		'{  2,   2,  -8,   6,   1,   3,  -5,   4,   2,  -1 },
		'{ 10,  -2,   3,  -9,   4,   2,   6,  -3,   1,   5 },
		'{ -6,   4,   5,   1,  -2,   8,  -4,   3,   7,  -2 },
		'{  3,  -7,   2,   5,   6,  -1,   9,  -4,  -2,   4 },
		'{  1,   6,  -3,  -2,   8,   5,  -1,   6,  -5,   2 },
		'{ -9,  -5,  -6,  -4,  -8,  -3,  -7,  -2,  -6,  -5 },  // Never positive.
		'{ 12,  11,  10,  12,   9,  11,  12,  10,  11,  12 },  // Saturates on large inputs.
		'{  4,  -1,   7,  -3,   2,   6,  -2,   5,   3,  -4 }
	};

	localparam mlpTypes::weightT [0:`MLP_HIDDEN-1] hiddenBias =
	'{
		3, -5, 10, -8, 0, 6, -2, -1, 20, 4
	};

	// Hidden neuron 7 is always zero, so its column carries no weight.
	localparam mlpTypes::weightT [0:`MLP_CLASSES-1][0:`MLP_HIDDEN-1] outputWeights =
	'{
		'{  6,  -2,   4,   3,  -5,   2,   7,   0,   1,  -3 },
		'{ -3,   5,   2,  -4,   6,   1,  -2,   0,   3,   4 },
		'{  2,   3,  -4,   5,   1,  -3,   4,   0,  -2,   6 },
		'{  4,   1,   3,  -2,   2,   5,  -3,   0,   2,  -1 }
	};

	localparam mlpTypes::weightT [0:`MLP_CLASSES-1] outputBias =
	'{
		8, -4, 2, 0
	};

endpackage

// ==== source/neuronNode.sv ====
`include "mlp_consts.svh"

module neuronNode
#(
	parameter mlpTypes::weightT [0:`MLP_INPUTS-1] weights = '0,
	parameter mlpTypes::weightT bias = '0
)
(
	input logic clk,
	input logic reset,
	input mlpTypes::activationT [`MLP_INPUTS-1:0] activations,
	output mlpTypes::activationT activation
);

	mlpTypes::activationT [`MLP_INPUTS-1:0] actReg;
	mlpTypes::accumT sumNext;
	mlpTypes::accumT sumReg;

	// Activation is zero extended, weight sign extended, product kept at 16 bits.
	always_comb
	begin
		sumNext = {{8{bias[7]}}, bias};
		for (int i = 0; i < `MLP_INPUTS; i++)
		begin
			sumNext = sumNext + mlpTypes::productT'({8'b0, actReg[i]})
				* mlpTypes::productT'({{8{weights[i][7]}}, weights[i]});
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			actReg <= activations;
			sumReg <= sumNext;
			if (sumReg[15])
			begin
				activation <= '0;    // Negative sums rectify to zero.
			end
			else if (sumReg[14])
			begin
				activation <= 8'hFF;
			end
			else
			begin
				activation <= sumReg[`MLP_FRAC_SHIFT+7:`MLP_FRAC_SHIFT];
			end
		end
	end

endmodule

// ==== source/resultPort.sv ====
`include "mlp_consts.svh"

module resultPort
(
	input logic clk,
	input logic reset,
	input logic resValid,
	input mlpTypes::resultT result,
	output logic outReq,
	output mlpTypes::resultT outData,
	input logic outAck,
	output logic retire
);

	typedef enum logic [1:0] {idleSt, requestSt, waitReleaseSt} senderStateT;

	senderStateT state;
	mlpTypes::resultT queue [`MLP_RESULT_DEPTH];
	logic [$clog2(`MLP_RESULT_DEPTH)-1:0] wrPtr;
	logic [$clog2(`MLP_RESULT_DEPTH)-1:0] rdPtr;
	logic [$clog2(`MLP_RESULT_DEPTH+1)-1:0] count;
	logic pop;

	// The head entry stays put until the receiver has taken it.
	assign outData = queue[rdPtr];
	assign pop = (state == requestSt) && outAck;

	always_ff @(posedge clk)
	begin
		if (resValid)
		begin
			queue[wrPtr] <= result;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idleSt;
			outReq <= 1'b0;
			retire <= 1'b0;
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			retire <= pop;
			if (resValid)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			if (resValid && !pop)
			begin
				count <= count + 1'b1;
			end
			else if (pop && !resValid)
			begin
				count <= count - 1'b1;
			end
			case (state)
				idleSt:
				begin
					if (count != '0)
					begin
						outReq <= 1'b1;
						state <= requestSt;
					end
				end
				requestSt:
				begin
					if (outAck)
					begin
						outReq <= 1'b0;
						state <= waitReleaseSt;
					end
				end
				default:
				begin
					if (!outAck)
					begin
						state <= idleSt;    // Handshake closed.
					end
				end
			endcase
		end
	end

endmodule

// ==== test/tbMlp.sv ====
`include "mlp_consts.svh"

module tbMlp;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int waitLimit = 200;    // Cycles any single handshake wait may take.

	logic clk = 1'b0;
	logic reset;
	logic inReq;
	mlpTypes::featureVecT inData;
	logic inAck;
	logic outReq;
	mlpTypes::resultT outData;
	logic outAck;

	logic [31:0] lcgState;
	mlpTypes::resultT expected [$];
	mlpTypes::featureVecT streamVecs [100];
	int streamDelays [100];
	int errors = 0;
	int checks = 0;
	int passedTests = 0;
	int failedTests = 0;
	bit hung = 1'b0;

	mlpTop dut_i
	(
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic mlpTypes::featureVecT randomVector();
		mlpTypes::featureVecT v;
		logic [31:0] r;
		for (int i = 0; i < `MLP_INPUTS; i++)
		begin
			r = nextRand();
			v.act[i] = r[31:24];    // Upper bits of an LCG are the least regular.
		end
		return v;
	endfunction

	function automatic mlpTypes::featureVecT fillVector(mlpTypes::activationT even,
		mlpTypes::activationT odd);
		mlpTypes::featureVecT v;
		for (int i = 0; i < `MLP_INPUTS; i++)
		begin
			v.act[i] = (i % 2 == 0) ? even : odd;
		end
		return v;
	endfunction

	// Negative sums give zero, bit 14 saturates, otherwise the sum is rescaled.
	function automatic mlpTypes::activationT rectify(int acc);
		logic [15:0] wrapped;
		wrapped = acc[15:0];
		if (wrapped[15])
			return 8'd0;
		else if (wrapped[14])
			return 8'd255;
		return 8'(wrapped >> `MLP_FRAC_SHIFT);
	endfunction

	function automatic mlpTypes::resultT modelResult(mlpTypes::featureVecT f);
		mlpTypes::hiddenVecT h;
		mlpTypes::resultT r;
		int acc;
		for (int n = 0; n < `MLP_HIDDEN; n++)
		begin
			acc = int'(mlpWeights::hiddenBias[n]);
			for (int i = 0; i < `MLP_INPUTS; i++)
				acc += int'(f.act[i]) * int'(mlpWeights::hiddenWeights[n][i]);
			h.act[n] = rectify(acc);
		end
		for (int k = 0; k < `MLP_CLASSES; k++)
		begin
			acc = int'(mlpWeights::outputBias[k]);
			for (int i = 0; i < `MLP_HIDDEN; i++)
				acc += int'(h.act[i]) * int'(mlpWeights::outputWeights[k][i]);
			r.scores.score[k] = rectify(acc);
		end
		r.classIdx = '0;
		for (int k = 1; k < `MLP_CLASSES; k++)
		begin
			if (r.scores.score[k] > r.scores.score[r.classIdx])
				r.classIdx = mlpTypes::classIdxT'(k);    // Ties keep the lower index.
		end
		return r;
	endfunction

	task automatic checkClass(mlpTypes::classIdxT got, mlpTypes::classIdxT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH outData.classIdx got %h expected %h", got, exp);
		end
	endtask

	task automatic checkScores(mlpTypes::scoreVecT got, mlpTypes::scoreVecT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH outData.scores got %h expected %h", got, exp);
		end
	endtask

	// Both waits sample at the falling edge, where outputs are settled.
	task automatic waitInAck(logic level, output bit seen);
		seen = 1'b0;
		for (int c = 0; c < waitLimit && !seen; c++)
		begin
			@(negedge clk);
			seen = (inAck === level);
		end
		if (!seen)
		begin
			hung = 1'b1;
			$display("Timeout: inAck did not go to %0b within %0d cycles", level, waitLimit);
		end
	endtask

	task automatic waitOutReq(logic level, output bit seen);
		seen = 1'b0;
		for (int c = 0; c < waitLimit && !seen; c++)
		begin
			@(negedge clk);
			seen = (outReq === level);
		end
		if (!seen)
		begin
			hung = 1'b1;
			$display("Timeout: outReq did not go to %0b within %0d cycles", level, waitLimit);
		end
	endtask

	task automatic raiseRequest(mlpTypes::featureVecT f);
		expected.push_back(modelResult(f));
		@(posedge clk);
		#2;
		inData = f;
		inReq = 1'b1;
	endtask

	task automatic completeHandshake();
		bit seen;
		waitInAck(1'b1, seen);
		if (!seen)
			return;
		@(posedge clk);
		#2;
		inReq = 1'b0;
		waitInAck(1'b0, seen);
	endtask

	task automatic sendVector(mlpTypes::featureVecT f);
		if (hung)
			return;
		raiseRequest(f);
		completeHandshake();
	endtask

	task automatic receiveResult(int ackDelay);
		bit seen;
		mlpTypes::resultT got;
		mlpTypes::resultT exp;
		if (hung)
			return;
		waitOutReq(1'b1, seen);
		if (!seen)
			return;
		got = outData;
		if (expected.size() == 0)
		begin
			errors++;
			$display("A result was offered although no vector was outstanding");
		end
		else
		begin
			exp = expected.pop_front();
			checkClass(got.classIdx, exp.classIdx);
			checkScores(got.scores, exp.scores);
		end
		repeat (ackDelay) @(posedge clk);
		@(posedge clk);
		#2;
		outAck = 1'b1;
		waitOutReq(1'b0, seen);
		@(posedge clk);
		#2;
		outAck = 1'b0;
	endtask

	task automatic endTest(string name, int errorsBefore);
		if (errors == errorsBefore && !hung)
		begin
			passedTests++;
			$display("PASS %s", name);
		end
		else
		begin
			failedTests++;
			$display("FAIL %s (%0d errors)", name, errors - errorsBefore);
		end
	endtask

	initial
	begin
		int errorsBefore;
		lcgState = 32'd78558;
		reset = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		errorsBefore = errors;
		for (int c = 0; c < 10; c++)
		begin
			@(negedge clk);
			if (inAck !== 1'b0 || outReq !== 1'b0)
			begin
				errors++;
				$display("inAck or outReq is not low while idle after reset");
			end
		end
		endTest("idle after reset", errorsBefore);

		errorsBefore = errors;
		for (int v = 0; v < 40; v++)
		begin
			sendVector(randomVector());
			receiveResult(0);
		end
		endTest("single random vectors", errorsBefore);

		errorsBefore = errors;
		sendVector(fillVector(8'd0, 8'd0));
		receiveResult(0);
		sendVector(fillVector(8'd255, 8'd255));
		receiveResult(0);
		sendVector(fillVector(8'd255, 8'd0));
		receiveResult(0);
		sendVector(fillVector(8'd0, 8'd255));
		receiveResult(0);
		sendVector(fillVector(8'd128, 8'd128));
		receiveResult(0);
		sendVector(fillVector(8'd40, 8'd200));
		receiveResult(0);
		endTest("rectify corners", errorsBefore);

		// Small inputs leave every score at zero, so all four classes tie.
		errorsBefore = errors;
		sendVector(fillVector(8'd0, 8'd0));
		receiveResult(1);
		sendVector(fillVector(8'd1, 8'd1));
		receiveResult(0);
		sendVector(fillVector(8'd2, 8'd0));
		receiveResult(2);
		sendVector(fillVector(8'd0, 8'd1));
		receiveResult(0);
		endTest("tied scores", errorsBefore);

		errorsBefore = errors;
		for (int v = 0; v < `MLP_RESULT_DEPTH; v++)
			sendVector(randomVector());
		if (!hung)
		begin
			raiseRequest(randomVector());
			for (int c = 0; c < 40; c++)
			begin
				@(negedge clk);
				if (inAck === 1'b1)
				begin
					errors++;
					$display("inAck answered a request while no credit was free");
				end
			end
			fork
				completeHandshake();
				repeat (`MLP_RESULT_DEPTH + 1) receiveResult(0);
			join
		end
		endTest("back-pressure", errorsBefore);

		errorsBefore = errors;
		for (int v = 0; v < 100; v++)
		begin
			streamVecs[v] = randomVector();
			streamDelays[v] = nextRand() % 5;
		end
		fork
			for (int v = 0; v < 100; v++)
				sendVector(streamVecs[v]);
			for (int v = 0; v < 100; v++)
				receiveResult(streamDelays[v]);
		join
		if (expected.size() != 0)
		begin
			errors++;
			$display("%0d results never came out", expected.size());
		end
		endTest("streaming", errorsBefore);

		$display("%0d tests: %0d passed, %0d failed; %0d checks, %0d errors",
			passedTests + failedTests, passedTests, failedTests, checks, errors);
		if (failedTests == 0 && errors == 0 && !hung)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
